/* verilog.f */
+incdir+verification
logic/cpu_pkg.sv
logic/id_bus_if.sv
logic/gpr_file.sv
logic/fcc_reg.sv
logic/branch_unit.sv
logic/decode_latch.sv
logic/pc_unit.sv
logic/branch_front_end.sv
verification/tb_branch_front_end.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f verilog.f --top-module tb_branch_front_end -o sim_branch_front_end
./obj_dir/sim_branch_front_end 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

/* verification/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Mirror of the architectural state, advanced once per clock
word_t      m_regs [32]; // GPR contents
fcc_t       m_fcc;       // Condition codes as held, no bypass
inst_addr_t m_pc;        // pc of the instruction in decode
inst_t      m_inst;      // Instruction in decode
inst_addr_t m_fetch;     // Expected fetch_pc

task automatic model_reset(input inst_addr_t boot);
	for (int i = 0; i < 32; i++)
		m_regs[i] = '0;
	m_fcc   = '0;
	m_pc    = boot;
	m_inst  = NOP_INST; // Latch comes out of reset empty
	m_fetch = boot;
endtask

// GPR value seen by decode, a same-cycle writeback wins
function automatic word_t model_read(input reg_addr_t a, input logic wen,
		input reg_addr_t wa, input word_t wd);
	if (a == 5'd0)
		return '0;
	if (wen && wa == a)
		return wd;
	return m_regs[a];
endfunction

// Branch rules for one decode instruction
function automatic void model_resolve(input inst_t w, input inst_addr_t pc,
		input word_t a, input word_t b, input fcc_t cc,
		output logic br, output logic tk, output inst_addr_t tg);
	inst_addr_t seq;
	inst_addr_t rel;
	seq = pc + 32'd4;                                  // Delay-slot address
	rel = seq + {{14{w[15]}}, w[15:0], 2'b00};
	br  = 1'b0;
	tk  = 1'b0;
	tg  = '0;
	case (w[31:26])
		SPECIAL: if (w[5:0] == 6'd8 || w[5:0] == 6'd9) begin
			br = 1'b1;
			tk = 1'b1;
			tg = a;
		end
		J, JAL: begin
			br = 1'b1;
			tk = 1'b1;
			tg = {seq[31:28], w[25:0], 2'b00};
		end
		BEQ:  begin br = 1'b1; tk = (a == b);              tg = rel; end
		BNE:  begin br = 1'b1; tk = (a != b);              tg = rel; end
		BLEZ: begin br = 1'b1; tk = a[31] || a == '0;      tg = rel; end
		BGTZ: begin br = 1'b1; tk = !a[31] && a != '0;     tg = rel; end
		REGIMM: if (w[19:17] == 3'b000) begin
			br = 1'b1;
			tk = (a[31] != w[16]); // Bit 16 picks the >= 0 sense
			tg = rel;
		end
		COP1: if (w[25:21] == BC && !w[17]) begin
			br = 1'b1;
			tk = (cc[w[20:18]] == w[16]); // BC1T wants a set flag
			tg = rel;
		end
		default: ;
	endcase
endfunction

// One clock edge: fetch, IF/ID latch, GPR and cc writes
task automatic model_step(input inst_t fetched, input logic taken, input inst_addr_t target,
		input logic wen, input reg_addr_t wa, input word_t wd,
		input logic cwe, input logic [2:0] ci, input logic cv);
	m_pc    = m_fetch;
	m_inst  = fetched;
	m_fetch = taken ? target : m_fetch + 32'd4;
	if (wen && wa != 5'd0)
		m_regs[wa] = wd;
	if (cwe)
		m_fcc[ci] = cv; // Seen by decode from the next cycle on
endtask

`endif

/* verification/tb_branch_front_end.sv */
`timescale 1ns/10ps

module tb_branch_front_end import cpu_pkg::*; ();

	localparam inst_addr_t RESET_PC = 32'h8000_0400; // Boot address other than the package default
	localparam int CLK_PERIOD  = 40;
	localparam int RST_CYCLES  = 5;
	localparam int N_INST      = 2000;
	localparam int WATCHDOG_NS = (RST_CYCLES + N_INST + 20) * CLK_PERIOD;

	logic       clk;
	logic       rst;
	inst_t      inst;
	logic       wb_en;
	reg_addr_t  wb_addr;
	word_t      wb_data;
	logic       fcc_we;
	logic [2:0] fcc_idx;
	logic       fcc_val;
	inst_addr_t fetch_pc;
	logic       is_branch;
	logic       jump;
	inst_addr_t jump_to;

	integer seed;
	string  fetch_name; // Class of the word driven this cycle
	string  dec_name;   // Class of the word in decode
	string  prev_name;  // Class that set the current fetch_pc

	`include "tb_model.svh"

	branch_front_end #(.RESET_PC(RESET_PC)) UUT (
		.clk       (clk),
		.rst       (rst),
		.inst      (inst),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.fcc_we    (fcc_we),
		.fcc_idx   (fcc_idx),
		.fcc_val   (fcc_val),
		.fetch_pc  (fetch_pc),
		.is_branch (is_branch),
		.jump      (jump),
		.jump_to   (jump_to)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			$display("Done: errors found");
			$fatal(1, "Output check failed");
		end
	endtask

	// Weighted mix with operands mostly from r0..r7
	task automatic make_inst(output inst_t w, output string name);
		logic [31:0] f;
		logic [31:0] o;
		logic [31:0] s;
		f = $random(seed);
		o = $random(seed);
		s = $random(seed);
		case (s[3:0])
			4'd0: begin
				w    = {J, o[25:0]};
				name = "J";
			end
			4'd1: begin
				w    = {JAL, o[25:0]};
				name = "JAL";
			end
			4'd2: begin
				w    = {SPECIAL, 2'b00, f[2:0], 15'd0, FUNCT_JR};
				name = "JR";
			end
			4'd3: begin
				w    = {SPECIAL, 2'b00, f[2:0], 5'd0, 5'd31, 5'd0, FUNCT_JALR};
				name = "JALR";
			end
			4'd4: begin
				w    = {BEQ, 2'b00, f[2:0], 2'b00, f[5:3], o[15:0]};
				name = "BEQ";
			end
			4'd5: begin
				w    = {BNE, 2'b00, f[2:0], 2'b00, f[5:3], o[15:0]};
				name = "BNE";
			end
			4'd6: begin
				w    = {BLEZ, 2'b00, f[2:0], f[10:6], o[15:0]}; // rt junk
				name = "BLEZ";
			end
			4'd7: begin
				w    = {BGTZ, 2'b00, f[2:0], f[10:6], o[15:0]};
				name = "BGTZ";
			end
			4'd8, 4'd9: begin
				w    = {REGIMM, 2'b00, f[2:0], s[5], 3'b000, s[4], o[15:0]}; // Link in s[5]
				name = "REGIMM";
			end
			4'd10, 4'd11: begin
				w    = {COP1, BC, f[8:6], 1'b0, s[4], o[15:0]};
				name = "BC1";
			end
			default: begin
				w    = o; // Mostly non-branch
				name = "RANDOM";
			end
		endcase
	endtask

	// GPR and cc writeback traffic
	task automatic drive_writes();
		logic [31:0] a;
		logic [31:0] b;
		a = $random(seed);
		b = $random(seed);
		wb_en   = a[0] | a[1];
		wb_addr = (a[4:2] != 3'd0) ? {2'b00, a[7:5]} : a[12:8];
		case (a[14:13])
			2'd0: wb_data = m_regs[{2'b00, a[17:15]}]; // Copy of a live register for BEQ hits
			2'd1: wb_data = {1'b1, b[30:0]};           // Negative
			2'd2: wb_data = {27'd0, b[4:0]};           // Small values and now and then zero
			default: wb_data = b;
		endcase
		fcc_we  = a[20];
		fcc_idx = a[23:21];
		fcc_val = a[24];
	endtask

	// Compare outputs with the model and advance it past the coming edge
	task automatic check_cycle();
		logic       br;
		logic       tk;
		inst_addr_t tg;
		word_t      ra;
		word_t      rb;
		ra = model_read(m_inst[25:21], wb_en, wb_addr, wb_data);
		rb = model_read(m_inst[20:16], wb_en, wb_addr, wb_data);
		model_resolve(m_inst, m_pc, ra, rb, m_fcc, br, tk, tg);
		check({dec_name, " is_branch"}, 32'(br), 32'(is_branch));
		check({dec_name, " jump"}, 32'(tk), 32'(jump));
		check({dec_name, " jump_to"}, tg, jump_to);
		check({"fetch_pc after ", prev_name}, m_fetch, fetch_pc);
		model_step(inst, tk, tg, wb_en, wb_addr, wb_data, fcc_we, fcc_idx, fcc_val);
		prev_name = dec_name;
		dec_name  = fetch_name;
	endtask

	initial begin
		seed       = 32'h4876f379;
		clk        = 1'b0;
		rst        = 1'b1;
		inst       = NOP_INST;
		wb_en      = 1'b0;
		wb_addr    = '0;
		wb_data    = '0;
		fcc_we     = 1'b0;
		fcc_idx    = '0;
		fcc_val    = 1'b0;
		fetch_name = "NOP";
		dec_name   = "NOP";
		prev_name  = "reset";
		model_reset(RESET_PC);
		repeat (RST_CYCLES) @(posedge clk);
		for (int n = 0; n < N_INST; n++) begin
			#2;
			rst = 1'b0;
			make_inst(inst, fetch_name);
			drive_writes();
			@(negedge clk); // Combinational outputs settled
			if (n == 0) begin
				check("reset is_branch", 32'd0, 32'(is_branch));
				check("reset jump", 32'd0, 32'(jump));
				check("reset jump_to", 32'd0, jump_to);
				check("reset fetch_pc", RESET_PC, fetch_pc);
			end
			check_cycle();
			@(posedge clk);
		end
		$display("Done: no errors");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* logic/branch_front_end.sv */
`timescale 1ns/10ps

module branch_front_end import cpu_pkg::*; #(
	parameter inst_addr_t RESET_PC = DEFAULT_RESET_PC
) (
	input  logic       clk,
	input  logic       rst,
	input  inst_t      inst,      // Instruction at fetch_pc
	input  logic       wb_en,     // GPR writeback
	input  reg_addr_t  wb_addr,
	input  word_t      wb_data,
	input  logic       fcc_we,    // FPU compare writeback
	input  logic [2:0] fcc_idx,
	input  logic       fcc_val,
	output inst_addr_t fetch_pc,
	output logic       is_branch,
	output logic       jump,
	output inst_addr_t jump_to
);

	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;
	fcc_t      fcc;

	id_bus_if id_bus ();

	pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
		.clk      (clk),
		.rst      (rst),
		.jump     (jump),
		.jump_to  (jump_to),
		.fetch_pc (fetch_pc)
	);

	decode_latch #(.RESET_PC(RESET_PC)) u_decode_latch (
		.clk      (clk),
		.rst      (rst),
		.fetch_pc (fetch_pc),
		.inst     (inst),
		.rdata1   (rdata1),
		.rdata2   (rdata2),
		.raddr1   (raddr1),
		.raddr2   (raddr2),
		.id_bus   (id_bus.source)
	);

	gpr_file u_gpr_file (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.wen    (wb_en),
		.waddr  (wb_addr),
		.wdata  (wb_data),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	fcc_reg u_fcc_reg (
		.clk (clk),
		.rst (rst),
		.we  (fcc_we),
		.idx (fcc_idx),
		.val (fcc_val),
		.fcc (fcc)
	);

	branch_unit u_branch_unit (
		.id_bus    (id_bus.sink),
		.fcc       (fcc),
		.is_branch (is_branch),
		.jump      (jump),
		.jump_to   (jump_to)
	);

endmodule

/* logic/pc_unit.sv */
`timescale 1ns/10ps

module pc_unit import cpu_pkg::*; #(
	parameter inst_addr_t RESET_PC = DEFAULT_RESET_PC
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       jump,    // Taken branch in decode
	input  inst_addr_t jump_to,
	output inst_addr_t fetch_pc
);

	inst_addr_t next_pc;

	// Redirect lands after the delay slot, which is being fetched now
	assign next_pc = jump ? jump_to : fetch_pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst)
			fetch_pc <= RESET_PC; // Boot vector
		else
			fetch_pc <= next_pc;
	end

endmodule

/* logic/decode_latch.sv */
`timescale 1ns/10ps

module decode_latch import cpu_pkg::*; #(
	parameter inst_addr_t RESET_PC = DEFAULT_RESET_PC
) (
	input  logic       clk,
	input  logic       rst,
	input  inst_addr_t fetch_pc, // Address of inst
	input  inst_t      inst,     // Fetched word
	input  word_t      rdata1,   // GPR[rs] from the register file
	input  word_t      rdata2,   // GPR[rt]
	output reg_addr_t  raddr1,
	output reg_addr_t  raddr2,
	id_bus_if.source   id_bus
);

	inst_addr_t pc_q;
	inst_t      inst_q;

	// IF/ID register, no stall so it loads every cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q   <= RESET_PC;
			inst_q <= NOP_INST; // Decodes as no branch
		end else begin
			pc_q   <= fetch_pc;
			inst_q <= inst;
		end
	end

	// Register read addresses straight from the latched word
	assign raddr1 = inst_q[25:21]; // rs
	assign raddr2 = inst_q[20:16]; // rt

	// Decode bundle out to the branch unit
	assign id_bus.pc   = pc_q;
	assign id_bus.inst = inst_q;
	assign id_bus.reg1 = rdata1;
	assign id_bus.reg2 = rdata2;

endmodule

/* logic/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit import cpu_pkg::*; (
	id_bus_if.sink     id_bus,
	input  fcc_t       fcc,
	output logic       is_branch, // Control-flow instruction in decode
	output logic       jump,      // Taken
	output inst_addr_t jump_to    // Redirect address, zero when not a branch
);

	opcode_e    opcode;
	regimm_rt_e rt_code;
	cop1_fmt_e  fmt;
	logic [5:0] funct;
	logic [15:0] offset;
	logic [25:0] instr_index;
	logic [2:0] cc_sel;
	logic       cc_sense;

	inst_addr_t pc_plus4;
	inst_addr_t target_i;
	inst_addr_t target_j;
	logic       reg_equal;
	logic       reg1_zero;
	logic       reg1_neg;

	// Field split
	assign opcode      = opcode_e'(id_bus.inst[31:26]);
	assign fmt         = cop1_fmt_e'(id_bus.inst[25:21]);  // COP1 rs
	assign rt_code     = regimm_rt_e'(id_bus.inst[20:16]); // REGIMM rt
	assign funct       = id_bus.inst[5:0];
	assign offset      = id_bus.inst[15:0];
	assign instr_index = id_bus.inst[25:0];
	assign cc_sel      = id_bus.inst[20:18]; // BC1x cc number
	assign cc_sense    = id_bus.inst[16];    // 1 for BC1T, 0 for BC1F

	// Targets are relative to the delay slot
	assign pc_plus4 = id_bus.pc + 32'd4;
	assign target_i = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
	assign target_j = {pc_plus4[31:28], instr_index, 2'b00}; // Same 256 MB region

	// Operand compares
	assign reg_equal = (id_bus.reg1 == id_bus.reg2);
	assign reg1_zero = (id_bus.reg1 == '0);
	assign reg1_neg  = id_bus.reg1[31];

	always_comb begin
		// Not a branch unless a case below says so
		is_branch = 1'b0;
		jump      = 1'b0;
		jump_to   = '0;

		case (opcode)
			SPECIAL: begin
				if (funct == FUNCT_JR || funct == FUNCT_JALR) begin
					is_branch = 1'b1;
					jump      = 1'b1;
					jump_to   = id_bus.reg1; // Register target
				end
			end
			J, JAL: begin
				is_branch = 1'b1;
				jump      = 1'b1;
				jump_to   = target_j;
			end
			BEQ: begin
				is_branch = 1'b1;
				jump      = reg_equal;
				jump_to   = target_i;
			end
			BNE: begin
				is_branch = 1'b1;
				jump      = ~reg_equal;
				jump_to   = target_i;
			end
			BLEZ: begin // rt ignored here
				is_branch = 1'b1;
				jump      = reg1_neg | reg1_zero;
				jump_to   = target_i;
			end
			BGTZ: begin
				is_branch = 1'b1;
				jump      = ~reg1_neg & ~reg1_zero;
				jump_to   = target_i;
			end
			REGIMM: begin
				// Link variants resolve like the plain ones
				case (rt_code)
					BLTZ, BLTZAL: begin
						is_branch = 1'b1;
						jump      = reg1_neg;
						jump_to   = target_i;
					end
					BGEZ, BGEZAL: begin
						is_branch = 1'b1;
						jump      = ~reg1_neg;
						jump_to   = target_i;
					end
					default: ; // Traps and others, not control flow
				endcase
			end
			COP1: begin
				// Bit 17 set would be the likely form, not handled
				if (fmt == BC && !id_bus.inst[17]) begin
					is_branch = 1'b1;
					jump      = (fcc[cc_sel] == cc_sense);
					jump_to   = target_i;
				end
			end
			default: ;
		endcase
	end

endmodule

/* logic/fcc_reg.sv */
`timescale 1ns/10ps

module fcc_reg import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       we,  // Compare result strobe
	input  logic [2:0] idx, // Which cc to update
	input  logic       val, // Compare outcome
	output fcc_t       fcc
);

	fcc_t flags;

	// One flag per cycle, others hold
	// No bypass, so a branch sees the new value one cycle later
	always_ff @(posedge clk) begin
		if (rst)
			flags <= '0;
		else if (we)
			flags[idx] <= val;
	end

	assign fcc = flags; // Read by BC1F/BC1T in decode

endmodule

/* logic/gpr_file.sv */
`timescale 1ns/10ps

module gpr_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t raddr1, // rs
	input  reg_addr_t raddr2, // rt
	input  logic      wen,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	output word_t     rdata1,
	output word_t     rdata2
);

	word_t regs [32];

	// Write port, r0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Read ports with write-through, so decode sees a same-cycle writeback
	always_comb begin
		if (raddr1 == '0)
			rdata1 = '0;                 // Hardwired zero
		else if (wen && waddr == raddr1)
			rdata1 = wdata;              // Bypass
		else
			rdata1 = regs[raddr1];

		if (raddr2 == '0)
			rdata2 = '0;
		else if (wen && waddr == raddr2)
			rdata2 = wdata;
		else
			rdata2 = regs[raddr2];
	end

endmodule

/* logic/id_bus_if.sv */
`timescale 1ns/10ps

// Decode-stage bundle, IF/ID latch to branch unit
interface id_bus_if import cpu_pkg::*; ();

	inst_addr_t pc;   // Address of the instruction in decode
	inst_t      inst; // Latched instruction
	word_t      reg1; // GPR[rs]
	word_t      reg2; // GPR[rt]

	// Decode latch side
	modport source (
		output pc,
		output inst,
		output reg1,
		output reg2
	);

	// Branch unit side
	modport sink (
		input pc,
		input inst,
		input reg1,
		input reg2
	);

endinterface

/* logic/cpu_pkg.sv */
package cpu_pkg;

	// Basic datapath widths
	typedef logic [31:0] word_t;      // GPR data word
	typedef logic [31:0] inst_addr_t; // Byte address of an instruction
	typedef logic [31:0] inst_t;      // Raw instruction word
	typedef logic [4:0]  reg_addr_t;  // GPR index, r0..r31
	typedef logic [7:0]  fcc_t;       // FPU compare flags, cc0..cc7

	// Primary opcode, inst[31:26]
	// Only the encodings that matter for control flow
	typedef enum logic [5:0] {
		SPECIAL = 6'b000000, // R-type, funct picks JR/JALR
		REGIMM  = 6'b000001, // rt field picks the compare-with-zero form
		J       = 6'b000010,
		JAL     = 6'b000011,
		BEQ     = 6'b000100,
		BNE     = 6'b000101,
		BLEZ    = 6'b000110,
		BGTZ    = 6'b000111,
		COP1    = 6'b010001  // FPU, BC1F/BC1T when rs is BC
	} opcode_e;

	// REGIMM sub-codes in the rt field, inst[20:16]
	// Bit 0 is the "greater or equal" sense, bit 4 the link
	typedef enum logic [4:0] {
		BLTZ   = 5'b00000,
		BGEZ   = 5'b00001,
		BLTZAL = 5'b10000,
		BGEZAL = 5'b10001
	} regimm_rt_e;

	// COP1 rs sub-code, inst[25:21]
	typedef enum logic [4:0] {
		BC = 5'b01000 // Branch on FPU condition
	} cop1_fmt_e;

	// SPECIAL funct codes for register jumps
	localparam logic [5:0] FUNCT_JR   = 6'b001000;
	localparam logic [5:0] FUNCT_JALR = 6'b001001;

	// sll r0, r0, 0
	localparam inst_t NOP_INST = 32'h0000_0000;

	// Boot vector in kseg1, default for the RESET_PC parameters
	localparam inst_addr_t DEFAULT_RESET_PC = 32'hbfc0_0000;

endpackage
